//--- hdl/l2_pkg.sv
package l2_pkg;

	//////////////////////////////////////////////////////////////////////
	// address split: tag | index | offset
	//////////////////////////////////////////////////////////////////////
	localparam int ADDR_W     = 32;
	localparam int LINE_W     = 128;
	localparam int LINE_IDX_W = 10;
	localparam int OFFSET_W   = 4;
	localparam int TAG_W      = ADDR_W - LINE_IDX_W - OFFSET_W;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [LINE_IDX_W-1:0] idx_t;

	typedef enum logic [2:0] {
		req_none,
		req_i_rd,
		req_d_rd,
		req_d_wr,
		req_tag_ld,
		req_tag_st
	} req_kind_e;

	// tag ops carry the index in addr and the tag word in the low bits of wdata
	typedef struct packed {
		req_kind_e kind;
		addr_t     addr;
		line_t     wdata;
	} l2_req_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} l2_meta_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_wb,
		st_fill,
		st_update,
		st_resp
	} ctrl_state_e;

endpackage

//--- hdl/cache_mem.sv
`timescale 1ns/10ps

module cache_mem #(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic [ADDR_W-1:0] i_raddr,
	input  logic [ADDR_W-1:0] i_waddr,
	input  logic [DATA_W-1:0] i_wdata,
	input  logic              i_we,
	output logic [DATA_W-1:0] o_rdata
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// same-address write and read in one cycle returns the old word
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		o_rdata <= mem[i_raddr];
	end

endmodule

//--- hdl/l2_req_arb.sv
`timescale 1ns/10ps

module l2_req_arb #(
	parameter int LINE_IDX_W = l2_pkg::LINE_IDX_W
) (
	input  logic            clk,
	input  logic            i_rst_n,
	input  logic            i_d_rd,
	input  logic            i_d_wr,
	input  l2_pkg::addr_t   i_d_addr,
	input  l2_pkg::line_t   i_d_wdata,
	input  logic            i_i_rd,
	input  l2_pkg::addr_t   i_i_addr,
	input  logic            i_op_load,
	input  logic            i_op_store,
	input  l2_pkg::addr_t   i_op_index,
	input  logic [31:0]     i_tag_lo,
	input  logic            i_idle,
	output l2_pkg::l2_req_t o_req
);

	l2_pkg::req_kind_e kind_nxt;
	l2_pkg::req_kind_e kind_q;
	l2_pkg::addr_t     addr_nxt;
	l2_pkg::addr_t     addr_q;
	l2_pkg::line_t     wdata_nxt;
	l2_pkg::line_t     wdata_q;
	l2_pkg::addr_t     op_addr;

	// tag ops only care about the index field
	always_comb begin
		op_addr = '0;
		op_addr[l2_pkg::OFFSET_W +: LINE_IDX_W] = i_op_index[l2_pkg::OFFSET_W +: LINE_IDX_W];
	end

	// priority: tag op, data, instruction
	always_comb begin
		kind_nxt  = l2_pkg::req_none;
		addr_nxt  = i_d_addr;
		wdata_nxt = i_d_wdata;
		if (i_op_store) begin
			kind_nxt  = l2_pkg::req_tag_st;
			addr_nxt  = op_addr;
			wdata_nxt = {{(l2_pkg::LINE_W-32){1'b0}}, i_tag_lo};
		end else if (i_op_load) begin
			kind_nxt = l2_pkg::req_tag_ld;
			addr_nxt = op_addr;
		end else if (i_d_wr) begin
			kind_nxt = l2_pkg::req_d_wr;
		end else if (i_d_rd) begin
			kind_nxt = l2_pkg::req_d_rd;
		end else if (i_i_rd) begin
			kind_nxt = l2_pkg::req_i_rd;
			addr_nxt = i_i_addr;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			kind_q <= l2_pkg::req_none;
		end else if (i_idle) begin
			kind_q <= kind_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (i_idle) begin
			addr_q  <= addr_nxt;
			wdata_q <= wdata_nxt;
		end
	end

	assign o_req.kind  = kind_q;
	assign o_req.addr  = addr_q;
	assign o_req.wdata = wdata_q;

	// controller works on one request until it goes idle again
	a_hold_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		!i_idle |=> $stable(o_req.kind));

endmodule

//--- hdl/l2_tag_store.sv
`timescale 1ns/10ps

module l2_tag_store #(
	parameter int LINE_IDX_W = l2_pkg::LINE_IDX_W
) (
	input  logic             clk,
	input  logic             i_rst_n,
	input  l2_pkg::l2_req_t  i_req,
	input  logic             i_meta_we,
	input  l2_pkg::l2_meta_t i_meta_wdata,
	output l2_pkg::l2_meta_t o_meta,
	output logic             o_hit,
	output logic             o_init_done
);

	logic [LINE_IDX_W-1:0] req_idx;
	logic [LINE_IDX_W-1:0] sweep_idx;
	logic [LINE_IDX_W-1:0] waddr;
	logic                  init_done_q;
	l2_pkg::tag_t          req_tag;
	logic                  v_we;
	logic                  v_wdata;
	logic                  v_rdata;
	logic                  d_rdata;
	l2_pkg::tag_t          t_rdata;

	assign req_idx = i_req.addr[l2_pkg::OFFSET_W +: LINE_IDX_W];
	assign req_tag = i_req.addr[l2_pkg::ADDR_W-1 -: l2_pkg::TAG_W];

	//////////////////////////////////////////////////////////////////////
	// reset sweep, clears one valid bit per cycle
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sweep_idx   <= '0;
			init_done_q <= 1'b0;
		end else if (!init_done_q) begin
			sweep_idx <= sweep_idx + LINE_IDX_W'(1);
			if (&sweep_idx) begin
				init_done_q <= 1'b1;
			end
		end
	end

	assign waddr   = init_done_q ? req_idx : sweep_idx;
	assign v_we    = i_meta_we | ~init_done_q;
	assign v_wdata = init_done_q & i_meta_wdata.valid;

	cache_mem #(.DATA_W(1), .ADDR_W(LINE_IDX_W)) u_valid_mem (
		.clk     (clk),
		.i_raddr (req_idx),
		.i_waddr (waddr),
		.i_wdata (v_wdata),
		.i_we    (v_we),
		.o_rdata (v_rdata)
	);

	cache_mem #(.DATA_W(1), .ADDR_W(LINE_IDX_W)) u_dirty_mem (
		.clk     (clk),
		.i_raddr (req_idx),
		.i_waddr (waddr),
		.i_wdata (i_meta_wdata.dirty),
		.i_we    (i_meta_we & init_done_q),
		.o_rdata (d_rdata)
	);

	cache_mem #(.DATA_W(l2_pkg::TAG_W), .ADDR_W(LINE_IDX_W)) u_tag_mem (
		.clk     (clk),
		.i_raddr (req_idx),
		.i_waddr (waddr),
		.i_wdata (i_meta_wdata.tag),
		.i_we    (i_meta_we & init_done_q),
		.o_rdata (t_rdata)
	);

	assign o_meta.valid = v_rdata;
	assign o_meta.dirty = d_rdata;
	assign o_meta.tag   = t_rdata;
	// tag ops ignore this
	assign o_hit        = v_rdata & (t_rdata == req_tag);
	assign o_init_done  = init_done_q;

endmodule

//--- hdl/l2_data_store.sv
`timescale 1ns/10ps

module l2_data_store #(
	parameter int LINE_IDX_W = l2_pkg::LINE_IDX_W
) (
	input  logic            clk,
	input  l2_pkg::l2_req_t i_req,
	input  logic            i_we,
	input  logic            i_src_client,
	input  logic            i_mem_ready,
	input  l2_pkg::line_t   i_mem_rdata,
	output l2_pkg::line_t   o_line,
	output l2_pkg::line_t   o_fill_line
);

	logic [LINE_IDX_W-1:0] idx;
	l2_pkg::line_t         fill_q;
	l2_pkg::line_t         wdata;

	assign idx = i_req.addr[l2_pkg::OFFSET_W +: LINE_IDX_W];

	// memory data is only valid in the ready pulse
	always_ff @(posedge clk) begin
		if (i_mem_ready) begin
			fill_q <= i_mem_rdata;
		end
	end

	assign wdata = i_src_client ? i_req.wdata : fill_q;

	cache_mem #(.DATA_W(l2_pkg::LINE_W), .ADDR_W(LINE_IDX_W)) u_line_mem (
		.clk     (clk),
		.i_raddr (idx),
		.i_waddr (idx),
		.i_wdata (wdata),
		.i_we    (i_we),
		.o_rdata (o_line)
	);

	assign o_fill_line = fill_q;

endmodule

//--- hdl/l2_ctrl.sv
`timescale 1ns/10ps

module l2_ctrl (
	input  logic             clk,
	input  logic             i_rst_n,
	input  l2_pkg::l2_req_t  i_req,
	input  logic             i_hit,
	input  l2_pkg::l2_meta_t i_meta,
	input  logic             i_init_done,
	input  logic             i_mem_ready,
	output logic             o_idle,
	output logic             o_meta_we,
	output l2_pkg::l2_meta_t o_meta_wdata,
	output logic             o_data_we,
	output logic             o_src_client,
	output logic             o_mem_rd,
	output logic             o_mem_wr,
	output logic             o_mem_wb,
	output logic             o_resp_from_fill,
	output logic             o_i_ready,
	output logic             o_d_ready,
	output logic             o_op_ready,
	output logic             o_tag_w
);

	localparam int META_W = $bits(l2_pkg::l2_meta_t);

	l2_pkg::ctrl_state_e state_q;
	l2_pkg::ctrl_state_e state_nxt;
	logic                armed_q;
	logic                from_fill_q;
	logic                accept;
	logic                victim_dirty;
	logic                is_write;
	logic                is_tag_op;
	logic                resp;
	l2_pkg::tag_t        req_tag;

	assign req_tag      = i_req.addr[l2_pkg::ADDR_W-1 -: l2_pkg::TAG_W];
	assign is_write     = (i_req.kind == l2_pkg::req_d_wr);
	assign is_tag_op    = (i_req.kind == l2_pkg::req_tag_ld) | (i_req.kind == l2_pkg::req_tag_st);
	assign victim_dirty = i_meta.valid & i_meta.dirty;

	// armed_q means the arbiter sampled fresh inputs at the last edge
	assign accept = (state_q == l2_pkg::st_idle) & armed_q & (i_req.kind != l2_pkg::req_none);
	assign o_idle = (state_q == l2_pkg::st_idle) & i_init_done & ~accept;

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			l2_pkg::st_idle: begin
				if (accept) begin
					state_nxt = l2_pkg::st_lookup;
				end
			end
			l2_pkg::st_lookup: begin
				if (is_tag_op || i_hit) begin
					state_nxt = l2_pkg::st_resp;
				end else if (victim_dirty) begin
					state_nxt = l2_pkg::st_wb;
				end else if (is_write) begin
					// full line write, nothing to fetch
					state_nxt = l2_pkg::st_resp;
				end else begin
					state_nxt = l2_pkg::st_fill;
				end
			end
			l2_pkg::st_wb: begin
				if (i_mem_ready) begin
					state_nxt = is_write ? l2_pkg::st_resp : l2_pkg::st_fill;
				end
			end
			l2_pkg::st_fill: begin
				if (i_mem_ready) begin
					state_nxt = l2_pkg::st_update;
				end
			end
			l2_pkg::st_update: state_nxt = l2_pkg::st_resp;
			default: state_nxt = l2_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q     <= l2_pkg::st_idle;
			armed_q     <= 1'b0;
			from_fill_q <= 1'b0;
		end else begin
			state_q <= state_nxt;
			armed_q <= o_idle;
			if (state_q == l2_pkg::st_idle) begin
				from_fill_q <= 1'b0;
			end else if (state_q == l2_pkg::st_fill && i_mem_ready) begin
				from_fill_q <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////////////////////////
	assign resp      = (state_q == l2_pkg::st_resp);
	assign o_mem_wr  = (state_q == l2_pkg::st_wb);
	assign o_mem_wb  = (state_q == l2_pkg::st_wb);
	assign o_mem_rd  = (state_q == l2_pkg::st_fill);

	// fill lands in update, client writes and tag stores at the ready edge
	assign o_data_we    = (state_q == l2_pkg::st_update) | (resp & is_write);
	assign o_src_client = is_write;
	assign o_meta_we    = (state_q == l2_pkg::st_update) |
		(resp & (is_write | (i_req.kind == l2_pkg::req_tag_st)));

	always_comb begin
		if (i_req.kind == l2_pkg::req_tag_st) begin
			o_meta_wdata = l2_pkg::l2_meta_t'(i_req.wdata[META_W-1:0]);
		end else begin
			o_meta_wdata.valid = 1'b1;
			o_meta_wdata.dirty = is_write;
			o_meta_wdata.tag   = req_tag;
		end
	end

	assign o_resp_from_fill = from_fill_q;
	assign o_i_ready  = resp & (i_req.kind == l2_pkg::req_i_rd);
	assign o_d_ready  = resp & ((i_req.kind == l2_pkg::req_d_rd) | is_write);
	assign o_op_ready = resp & is_tag_op;
	assign o_tag_w    = resp & (i_req.kind == l2_pkg::req_tag_ld);

	a_mem_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_mem_rd && o_mem_wr));

	a_ready_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
		$onehot0({o_i_ready, o_d_ready, o_op_ready}));

endmodule

//--- hdl/l2_cache_top.sv
`timescale 1ns/10ps

module l2_cache_top #(
	parameter int LINE_IDX_W = l2_pkg::LINE_IDX_W
) (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_d_rd,
	input  logic          i_d_wr,
	input  l2_pkg::addr_t i_d_addr,
	input  l2_pkg::line_t i_d_wdata,
	output logic          o_d_ready,
	input  logic          i_i_rd,
	input  l2_pkg::addr_t i_i_addr,
	output logic          o_i_ready,
	input  logic          i_op_load,
	input  logic          i_op_store,
	input  l2_pkg::addr_t i_op_index,
	input  logic [31:0]   i_tag_lo,
	output logic          o_op_ready,
	output logic [31:0]   o_tag_lo,
	output logic          o_tag_w,
	input  logic          i_mem_ready,
	input  l2_pkg::line_t i_mem_rdata,
	output l2_pkg::addr_t o_mem_addr,
	output l2_pkg::line_t o_mem_wdata,
	output logic          o_mem_rd,
	output logic          o_mem_wr,
	output l2_pkg::line_t o_rdata
);

	localparam int META_W = $bits(l2_pkg::l2_meta_t);

	// the tag field is fixed in the package, so the index width must agree
	if (l2_pkg::TAG_W + LINE_IDX_W + l2_pkg::OFFSET_W != l2_pkg::ADDR_W) begin : g_width_chk
		$error("LINE_IDX_W does not match the package tag width");
	end

	l2_pkg::l2_req_t  req;
	l2_pkg::l2_meta_t meta;
	l2_pkg::l2_meta_t meta_wdata;
	l2_pkg::line_t    line;
	l2_pkg::line_t    fill_line;
	logic             hit;
	logic             init_done;
	logic             idle;
	logic             meta_we;
	logic             data_we;
	logic             src_client;
	logic             mem_wb;
	logic             resp_from_fill;

	l2_req_arb #(.LINE_IDX_W(LINE_IDX_W)) u_req_arb (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_d_rd     (i_d_rd),
		.i_d_wr     (i_d_wr),
		.i_d_addr   (i_d_addr),
		.i_d_wdata  (i_d_wdata),
		.i_i_rd     (i_i_rd),
		.i_i_addr   (i_i_addr),
		.i_op_load  (i_op_load),
		.i_op_store (i_op_store),
		.i_op_index (i_op_index),
		.i_tag_lo   (i_tag_lo),
		.i_idle     (idle),
		.o_req      (req)
	);

	l2_tag_store #(.LINE_IDX_W(LINE_IDX_W)) u_tag_store (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_req        (req),
		.i_meta_we    (meta_we),
		.i_meta_wdata (meta_wdata),
		.o_meta       (meta),
		.o_hit        (hit),
		.o_init_done  (init_done)
	);

	l2_data_store #(.LINE_IDX_W(LINE_IDX_W)) u_data_store (
		.clk          (clk),
		.i_req        (req),
		.i_we         (data_we),
		.i_src_client (src_client),
		.i_mem_ready  (i_mem_ready),
		.i_mem_rdata  (i_mem_rdata),
		.o_line       (line),
		.o_fill_line  (fill_line)
	);

	l2_ctrl u_ctrl (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_req            (req),
		.i_hit            (hit),
		.i_meta           (meta),
		.i_init_done      (init_done),
		.i_mem_ready      (i_mem_ready),
		.o_idle           (idle),
		.o_meta_we        (meta_we),
		.o_meta_wdata     (meta_wdata),
		.o_data_we        (data_we),
		.o_src_client     (src_client),
		.o_mem_rd         (o_mem_rd),
		.o_mem_wr         (o_mem_wr),
		.o_mem_wb         (mem_wb),
		.o_resp_from_fill (resp_from_fill),
		.o_i_ready        (o_i_ready),
		.o_d_ready        (o_d_ready),
		.o_op_ready       (o_op_ready),
		.o_tag_w          (o_tag_w)
	);

	// victim address on write-back, request line otherwise
	always_comb begin
		if (mem_wb) begin
			o_mem_addr = {meta.tag, req.addr[l2_pkg::OFFSET_W +: LINE_IDX_W],
				{l2_pkg::OFFSET_W{1'b0}}};
		end else begin
			o_mem_addr = {req.addr[l2_pkg::ADDR_W-1:l2_pkg::OFFSET_W], {l2_pkg::OFFSET_W{1'b0}}};
		end
	end

	assign o_mem_wdata = line;
	assign o_rdata     = resp_from_fill ? fill_line : line;
	assign o_tag_lo    = {{(32-META_W){1'b0}}, meta};

endmodule

//--- verif/l2_cache_tb.sv
`timescale 1ns/10ps

module l2_cache_tb;

	localparam int READY_TIMEOUT = 100;
	localparam int INIT_TIMEOUT  = 2000;
	localparam int META_W        = $bits(l2_pkg::l2_meta_t);
	localparam int NUM_LINES     = 2**l2_pkg::LINE_IDX_W;

	// addresses as tag | index | offset
	localparam l2_pkg::addr_t A0  = {18'h00012, 10'h005, 4'h0};
	localparam l2_pkg::addr_t B0  = {18'h00034, 10'h005, 4'h0};
	localparam l2_pkg::addr_t C0  = {18'h00007, 10'h040, 4'h0};
	localparam l2_pkg::addr_t D0  = {18'h00008, 10'h040, 4'h0};
	localparam l2_pkg::addr_t E0  = {18'h0abcd, 10'h3ff, 4'h0};
	localparam l2_pkg::addr_t F0  = {18'h00111, 10'h200, 4'h0};
	localparam l2_pkg::addr_t X99 = {18'h00099, 10'h040, 4'h0};
	localparam l2_pkg::line_t W1  = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
	localparam l2_pkg::line_t W2  = 128'h9e37_79b9_0000_1111_2222_3333_c0de_f00d;

	typedef struct packed {
		l2_pkg::req_kind_e kind;
		logic              paired;
		l2_pkg::addr_t     addr;
		l2_pkg::line_t     wdata;
		l2_pkg::line_t     exp;
	} op_t;

	typedef struct packed {
		logic          wr;
		l2_pkg::addr_t addr;
		l2_pkg::line_t data;
	} mem_txn_t;

	logic          clk;
	logic          i_rst_n;
	logic          i_d_rd;
	logic          i_d_wr;
	l2_pkg::addr_t i_d_addr;
	l2_pkg::line_t i_d_wdata;
	logic          o_d_ready;
	logic          i_i_rd;
	l2_pkg::addr_t i_i_addr;
	logic          o_i_ready;
	logic          i_op_load;
	logic          i_op_store;
	l2_pkg::addr_t i_op_index;
	logic [31:0]   i_tag_lo;
	logic          o_op_ready;
	logic [31:0]   o_tag_lo;
	logic          o_tag_w;
	logic          i_mem_ready;
	l2_pkg::line_t i_mem_rdata;
	l2_pkg::addr_t o_mem_addr;
	l2_pkg::line_t o_mem_wdata;
	logic          o_mem_rd;
	logic          o_mem_wr;
	l2_pkg::line_t o_rdata;

	int            seed;
	op_t           ops [$];
	mem_txn_t      act_txn [$];
	mem_txn_t      exp_txn [$];
	l2_pkg::line_t mem_model [l2_pkg::addr_t];
	l2_pkg::line_t ref_mem [l2_pkg::addr_t];
	bit            ref_valid [NUM_LINES];
	bit            ref_dirty [NUM_LINES];
	l2_pkg::tag_t  ref_tag [NUM_LINES];
	l2_pkg::line_t ref_line [NUM_LINES];

	l2_cache_top #(.LINE_IDX_W(l2_pkg::LINE_IDX_W)) u_l2_cache_top (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_d_rd      (i_d_rd),
		.i_d_wr      (i_d_wr),
		.i_d_addr    (i_d_addr),
		.i_d_wdata   (i_d_wdata),
		.o_d_ready   (o_d_ready),
		.i_i_rd      (i_i_rd),
		.i_i_addr    (i_i_addr),
		.o_i_ready   (o_i_ready),
		.i_op_load   (i_op_load),
		.i_op_store  (i_op_store),
		.i_op_index  (i_op_index),
		.i_tag_lo    (i_tag_lo),
		.o_op_ready  (o_op_ready),
		.o_tag_lo    (o_tag_lo),
		.o_tag_w     (o_tag_w),
		.i_mem_ready (i_mem_ready),
		.i_mem_rdata (i_mem_rdata),
		.o_mem_addr  (o_mem_addr),
		.o_mem_wdata (o_mem_wdata),
		.o_mem_rd    (o_mem_rd),
		.o_mem_wr    (o_mem_wr),
		.o_rdata     (o_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [127:0] act, input logic [127:0] exp);
		if (act !== exp) begin
			fail_now($sformatf("Error: %s is 0x%h, expected 0x%h", name, act, exp));
		end
	endtask

	// every bit of the address shows up in the line
	function automatic l2_pkg::line_t line_pattern(input l2_pkg::addr_t a);
		return {a ^ 32'h5a5a_a5a5, ~a, {a[15:0], a[31:16]}, a + 32'h1357_9bdf};
	endfunction

	// valid, dirty, tag from the top down
	function automatic logic [31:0] tag_word(input logic v, input logic d, input l2_pkg::tag_t t);
		return {12'b0, v, d, t};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// operation table
	//////////////////////////////////////////////////////////////////////
	task automatic add_op(input l2_pkg::req_kind_e kind, input logic paired,
		input l2_pkg::addr_t addr, input l2_pkg::line_t wdata, input l2_pkg::line_t exp);
		op_t op;
		op.kind   = kind;
		op.paired = paired;
		op.addr   = addr;
		op.wdata  = wdata;
		op.exp    = exp;
		ops.push_back(op);
	endtask

	task automatic build_table();
		l2_pkg::addr_t idx40;
		l2_pkg::addr_t idx05;
		idx40 = {18'h0, 10'h040, 4'h0};
		idx05 = {18'h0, 10'h005, 4'h0};
		// cold miss, then hits on the same line
		add_op(l2_pkg::req_i_rd, 1'b0, A0 | 32'h4, '0, line_pattern(A0));
		add_op(l2_pkg::req_i_rd, 1'b0, A0, '0, line_pattern(A0));
		add_op(l2_pkg::req_d_rd, 1'b0, A0 | 32'h8, '0, line_pattern(A0));
		// full line write, read back
		add_op(l2_pkg::req_d_wr, 1'b0, C0, W1, '0);
		add_op(l2_pkg::req_d_rd, 1'b0, C0, W1, W1);
		// conflicts on dirty lines force a write-back first
		add_op(l2_pkg::req_i_rd, 1'b0, D0, '0, line_pattern(D0));
		add_op(l2_pkg::req_d_rd, 1'b0, C0, '0, W1);
		add_op(l2_pkg::req_d_wr, 1'b0, A0, W2, '0);
		add_op(l2_pkg::req_d_rd, 1'b0, B0, '0, line_pattern(B0));
		// tag port, then cache traffic driven by the stored metadata
		add_op(l2_pkg::req_tag_st, 1'b0, idx40, 128'(tag_word(1'b1, 1'b1, 18'h00099)), '0);
		add_op(l2_pkg::req_tag_ld, 1'b0, idx40, '0, 128'(tag_word(1'b1, 1'b1, 18'h00099)));
		add_op(l2_pkg::req_d_rd, 1'b0, X99, '0, W1);
		add_op(l2_pkg::req_i_rd, 1'b0, C0, '0, W1);
		add_op(l2_pkg::req_tag_st, 1'b0, idx05, 128'(tag_word(1'b0, 1'b0, 18'h00034)), '0);
		add_op(l2_pkg::req_tag_ld, 1'b0, idx05, '0, 128'(tag_word(1'b0, 1'b0, 18'h00034)));
		add_op(l2_pkg::req_d_rd, 1'b0, B0, '0, line_pattern(B0));
		// data and instruction raised together, data entry first
		add_op(l2_pkg::req_d_rd, 1'b1, E0, '0, line_pattern(E0));
		add_op(l2_pkg::req_i_rd, 1'b0, F0, '0, line_pattern(F0));
		add_op(l2_pkg::req_d_rd, 1'b1, E0, '0, line_pattern(E0));
		add_op(l2_pkg::req_i_rd, 1'b0, A0, '0, W2);
	endtask

	task automatic preload_memory();
		l2_pkg::addr_t a;
		foreach (ops[k]) begin
			a = {ops[k].addr[l2_pkg::ADDR_W-1:l2_pkg::OFFSET_W], 4'h0};
			mem_model[a] = line_pattern(a);
		end
	endtask

	function automatic l2_pkg::line_t mem_fetch(input l2_pkg::addr_t a);
		return mem_model.exists(a) ? mem_model[a] : '0;
	endfunction

	function automatic l2_pkg::line_t ref_read(input l2_pkg::addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : line_pattern(a);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// memory model, 2 to 5 cycles per access
	//////////////////////////////////////////////////////////////////////
	initial begin : mem_model_proc
		int       delay;
		mem_txn_t txn;
		seed        = 32'ha139;
		i_mem_ready = 1'b0;
		i_mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			if (o_mem_rd || o_mem_wr) begin
				delay = 2 + int'($random(seed) & 32'h3);
				repeat (delay - 1) @(posedge clk);
				#1;
				txn.wr   = o_mem_wr;
				txn.addr = o_mem_addr;
				if (o_mem_wr) begin
					txn.data = o_mem_wdata;
					mem_model[o_mem_addr] = o_mem_wdata;
				end else begin
					txn.data = mem_fetch(o_mem_addr);
				end
				act_txn.push_back(txn);
				i_mem_rdata = txn.data;
				i_mem_ready = 1'b1;
				@(posedge clk);
				#1;
				i_mem_ready = 1'b0;
			end
		end
	end

	// direct-mapped write-back rule, queues the expected memory traffic
	task automatic ref_access(input op_t op, output bit fixed);
		l2_pkg::idx_t     idx;
		l2_pkg::tag_t     tag;
		l2_pkg::addr_t    line_a;
		l2_pkg::l2_meta_t m;
		mem_txn_t         txn;
		idx    = op.addr[l2_pkg::OFFSET_W +: l2_pkg::LINE_IDX_W];
		tag    = op.addr[l2_pkg::ADDR_W-1 -: l2_pkg::TAG_W];
		line_a = {op.addr[l2_pkg::ADDR_W-1:l2_pkg::OFFSET_W], 4'h0};
		fixed  = 1'b1;
		if (op.kind == l2_pkg::req_tag_st) begin
			m = op.wdata[META_W-1:0];
			ref_valid[idx] = m.valid;
			ref_dirty[idx] = m.dirty;
			ref_tag[idx]   = m.tag;
		end else if (op.kind != l2_pkg::req_tag_ld) begin
			if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
				if (ref_valid[idx] && ref_dirty[idx]) begin
					txn.wr   = 1'b1;
					txn.addr = {ref_tag[idx], idx, 4'h0};
					txn.data = ref_line[idx];
					exp_txn.push_back(txn);
					ref_mem[txn.addr] = txn.data;
					fixed = 1'b0;
				end
				if (op.kind != l2_pkg::req_d_wr) begin
					txn.wr   = 1'b0;
					txn.addr = line_a;
					txn.data = ref_read(line_a);
					exp_txn.push_back(txn);
					ref_line[idx] = txn.data;
					fixed = 1'b0;
				end
				ref_valid[idx] = 1'b1;
				ref_dirty[idx] = 1'b0;
				ref_tag[idx]   = tag;
			end
			if (op.kind == l2_pkg::req_d_wr) begin
				ref_line[idx]  = op.wdata;
				ref_dirty[idx] = 1'b1;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// client side
	//////////////////////////////////////////////////////////////////////
	task automatic raise_req(input op_t op);
		case (op.kind)
			l2_pkg::req_i_rd: begin
				i_i_rd   = 1'b1;
				i_i_addr = op.addr;
			end
			l2_pkg::req_d_rd: begin
				i_d_rd   = 1'b1;
				i_d_addr = op.addr;
			end
			l2_pkg::req_d_wr: begin
				i_d_wr    = 1'b1;
				i_d_addr  = op.addr;
				i_d_wdata = op.wdata;
			end
			l2_pkg::req_tag_ld: begin
				i_op_load  = 1'b1;
				i_op_index = op.addr;
			end
			l2_pkg::req_tag_st: begin
				i_op_store = 1'b1;
				i_op_index = op.addr;
				i_tag_lo   = op.wdata[31:0];
			end
			default: ;
		endcase
	endtask

	task automatic drop_req(input l2_pkg::req_kind_e kind);
		case (kind)
			l2_pkg::req_i_rd: i_i_rd = 1'b0;
			l2_pkg::req_d_rd, l2_pkg::req_d_wr: begin
				i_d_rd = 1'b0;
				i_d_wr = 1'b0;
			end
			default: begin
				i_op_load  = 1'b0;
				i_op_store = 1'b0;
			end
		endcase
	endtask

	function automatic logic ready_of(input l2_pkg::req_kind_e kind);
		case (kind)
			l2_pkg::req_i_rd: return o_i_ready;
			l2_pkg::req_d_rd, l2_pkg::req_d_wr: return o_d_ready;
			default: return o_op_ready;
		endcase
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		while (u_l2_cache_top.idle !== 1'b1 && n < INIT_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (u_l2_cache_top.idle !== 1'b1) begin
			fail_now("the cache never became idle after reset");
		end
	endtask

	task automatic wait_ready(input l2_pkg::req_kind_e kind, input bit forbid_i, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			if (forbid_i && o_i_ready) begin
				fail_now("the instruction request was served before the data request");
			end
		end while (!ready_of(kind) && cycles < READY_TIMEOUT);
		if (!ready_of(kind)) begin
			fail_now($sformatf("timeout waiting for the ready of a %s request", kind.name()));
		end
	endtask

	task automatic check_result(input op_t op);
		case (op.kind)
			l2_pkg::req_i_rd, l2_pkg::req_d_rd: compare("o_rdata", o_rdata, op.exp);
			l2_pkg::req_tag_ld: compare("o_tag_lo", 128'(o_tag_lo), op.exp);
			default: ;
		endcase
		compare("o_tag_w", 128'(o_tag_w), 128'(op.kind == l2_pkg::req_tag_ld));
	endtask

	task automatic check_traffic();
		mem_txn_t a;
		mem_txn_t e;
		compare("memory access count", 128'(act_txn.size()), 128'(exp_txn.size()));
		while (exp_txn.size() > 0) begin
			a = act_txn.pop_front();
			e = exp_txn.pop_front();
			compare("o_mem_wr", 128'(a.wr), 128'(e.wr));
			compare("o_mem_addr", 128'(a.addr), 128'(e.addr));
			compare(a.wr ? "o_mem_wdata" : "i_mem_rdata", a.data, e.data);
		end
	endtask

	// hits and tag ops answer three edges after the request goes up
	task automatic serve_op(input op_t op, input bit forbid_i, input bit check_lat);
		bit fixed;
		int cycles;
		ref_access(op, fixed);
		wait_ready(op.kind, forbid_i, cycles);
		check_result(op);
		check_traffic();
		if (check_lat && fixed) begin
			compare("ready latency", 128'(cycles), 128'(3));
		end
		@(posedge clk);
		#1;
		drop_req(op.kind);
	endtask

	initial begin
		int k;
		i_rst_n    = 1'b0;
		i_d_rd     = 1'b0;
		i_d_wr     = 1'b0;
		i_d_addr   = '0;
		i_d_wdata  = '0;
		i_i_rd     = 1'b0;
		i_i_addr   = '0;
		i_op_load  = 1'b0;
		i_op_store = 1'b0;
		i_op_index = '0;
		i_tag_lo   = '0;
		build_table();
		preload_memory();
		repeat (10) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		wait_idle();
		k = 0;
		while (k < ops.size()) begin
			raise_req(ops[k]);
			if (ops[k].paired) begin
				raise_req(ops[k+1]);
				serve_op(ops[k], 1'b1, 1'b0);
				serve_op(ops[k+1], 1'b0, 1'b0);
				k += 2;
			end else begin
				serve_op(ops[k], 1'b0, 1'b1);
				k += 1;
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

//--- flist.f
hdl/l2_pkg.sv
hdl/cache_mem.sv
hdl/l2_req_arb.sv
hdl/l2_tag_store.sv
hdl/l2_data_store.sv
hdl/l2_ctrl.sv
hdl/l2_cache_top.sv
verif/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module l2_cache_tb -o l2_cache_sim

# the log decides the result, not the simulator's exit status
./obj_dir/l2_cache_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
